//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_msg_test
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(wildcard src/*.sv src/*.svh sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/msg_monitor.sv
`include "msg_settings.svh"

module msg_monitor (
	input  logic                      snk0_clk,
	input  logic                      arst_n,
	input  logic [1:0]                src_en,
	input  logic [1:0]                corrupt,
	input  logic                      err_clear,
	input  logic                      rx_valid,
	input  logic [`MSG_ADDR_SIZE-1:0] rx_src,
	input  logic [`MSG_ADDR_SIZE-1:0] rx_dst,
	input  logic [`MSG_DATA_SIZE-1:0] rx_dat,
	input  logic                      err_src0,
	input  logic                      err_src1,
	input  logic                      row_end,
	input  logic                      exp_err0,
	input  logic                      exp_err1,
	output int                        check_count,
	output int                        mismatch_count,
	output int                        other_count
);

	localparam logic [`MSG_ADDR_SIZE-1:0] SRC0_A = `MSG_ADDR_SIZE'(`MSG_SRC0_ADDR);
	localparam logic [`MSG_ADDR_SIZE-1:0] SRC1_A = `MSG_ADDR_SIZE'(`MSG_SRC1_ADDR);
	localparam logic [`MSG_ADDR_SIZE-1:0] MIN_A = `MSG_ADDR_SIZE'(`MSG_MIN_ADDR);
	localparam logic [`MSG_ADDR_SIZE-1:0] MAX_A = `MSG_ADDR_SIZE'(`MSG_MAX_ADDR);
	localparam logic [`MSG_ADDR_SIZE-1:0] ONE_A = `MSG_ADDR_SIZE'(1);
	localparam logic [`MSG_DATA_SIZE-1:0] SEQ_INIT = `MSG_DATA_SIZE'(15);
	localparam logic [`MSG_DATA_SIZE-1:0] SEQ_TOP = `MSG_DATA_SIZE'(14);
	localparam logic [`MSG_DATA_SIZE-1:0] DAT_ONE = `MSG_DATA_SIZE'(1);

	// Per-source model, index 0 and 1 follow the source number
	logic [`MSG_ADDR_SIZE-1:0] next_dst [2];
	logic [3:0]                next_nib [2];
	logic [`MSG_DATA_SIZE-1:0] last_dat [2];
	logic                      err_m    [2];
	logic                      ever_en  [2];
	int                        row_cnt  [2];
	logic                      row_both;
	logic                      row_any;
	int                        checks = 0;
	int                        mismatches = 0;
	int                        others = 0;

	assign check_count    = checks;
	assign mismatch_count = mismatches;
	assign other_count    = others;

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("mismatch at time %0t: %s expected %0h actual %0h", $time, name,
			expected, actual);
		mismatches++;
	endtask

	task automatic report_failure(input string what);
		$display("Error at time %0t: %s", $time, what);
		others++;
	endtask

	task automatic check_message();
		logic                      s;
		logic [`MSG_DATA_SIZE-1:0] exp_dat;
		checks++;
		if (rx_src != SRC0_A && rx_src != SRC1_A) begin
			report_failure($sformatf("message with unknown source address %0d", rx_src));
		end else begin
			s = (rx_src == SRC1_A);
			row_cnt[s]++;
			if (!ever_en[s]) begin
				report_failure($sformatf("message from source %0d, which was never enabled", s));
			end
			exp_dat = {{(`MSG_DATA_SIZE-4){1'b0}}, next_nib[s]};
			if (rx_dst !== next_dst[s]) begin
				report_mismatch("rx_dst", 32'(next_dst[s]), 32'(rx_dst));
			end
			if (rx_dat !== exp_dat) begin
				report_mismatch("rx_dat", 32'(exp_dat), 32'(rx_dat));
			end
			next_dst[s] = (next_dst[s] == MAX_A) ? MIN_A : next_dst[s] + ONE_A;
			next_nib[s] = next_nib[s] + 4'd1;
			// Sink only checks while the flag is clear
			if (!err_m[s]) begin
				if (corrupt[s]) begin
					err_m[s] = 1'b1;
				end else if (last_dat[s] <= SEQ_TOP && last_dat[s] + DAT_ONE != exp_dat) begin
					err_m[s] = 1'b1;
				end else begin
					last_dat[s] = exp_dat;
				end
			end
			if (err_src0 !== err_m[0]) begin
				report_mismatch("err_src0", 32'(err_m[0]), 32'(err_src0));
			end
			if (err_src1 !== err_m[1]) begin
				report_mismatch("err_src1", 32'(err_m[1]), 32'(err_src1));
			end
		end
	endtask

	task automatic finish_row();
		int total;
		total = row_cnt[0] + row_cnt[1];
		if (err_src0 !== exp_err0) begin
			report_mismatch("err_src0", 32'(exp_err0), 32'(err_src0));
		end
		if (err_src1 !== exp_err1) begin
			report_mismatch("err_src1", 32'(exp_err1), 32'(err_src1));
		end
		// Round robin: neither source below a third
		if (row_both && total >= 6) begin
			if (row_cnt[0] * 3 < total) begin
				report_failure($sformatf("source 0 starved, %0d of %0d messages", row_cnt[0], total));
			end
			if (row_cnt[1] * 3 < total) begin
				report_failure($sformatf("source 1 starved, %0d of %0d messages", row_cnt[1], total));
			end
		end
		if (row_any && total == 0) begin
			report_failure("no message arrived during a row with a source enabled");
		end
		row_cnt[0] = 0;
		row_cnt[1] = 0;
		row_both   = 1'b1;
		row_any    = 1'b1;
	endtask

	always @(posedge snk0_clk or negedge arst_n) begin
		if (!arst_n) begin
			next_dst[0] = MIN_A;
			next_dst[1] = MIN_A;
			next_nib[0] = 4'd0;
			next_nib[1] = 4'd0;
			last_dat[0] = SEQ_INIT;
			last_dat[1] = SEQ_INIT;
			err_m[0]    = 1'b0;
			err_m[1]    = 1'b0;
			ever_en[0]  = 1'b0;
			ever_en[1]  = 1'b0;
			row_cnt[0]  = 0;
			row_cnt[1]  = 0;
			row_both    = 1'b1;
			row_any     = 1'b1;
		end else begin
			if (src_en[0]) ever_en[0] = 1'b1;
			if (src_en[1]) ever_en[1] = 1'b1;
			if (src_en != 2'b11) row_both = 1'b0;
			if (src_en == 2'b00) row_any = 1'b0;
			if (rx_valid) check_message();
			if (row_end) finish_row();
			// Clear acts after the message checked in this cycle
			if (err_clear) begin
				err_m[0]    = 1'b0;
				err_m[1]    = 1'b0;
				last_dat[0] = SEQ_INIT;
				last_dat[1] = SEQ_INIT;
			end
		end
	end

endmodule

//--- sim/tb_msg_test.sv
`include "msg_settings.svh"

module tb_msg_test;

	typedef struct packed {
		logic [1:0]  en;
		logic [1:0]  corrupt;
		logic        clr;
		logic [15:0] cycles;
		logic        exp0;
		logic        exp1;
	} row_t;

	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 16;
	localparam int MARGIN_CYCLES = 200;

	logic                      snk0_clk;
	logic                      arst_n;
	logic [1:0]                src_en;
	logic [1:0]                corrupt;
	logic                      err_clear;
	logic                      rx_valid;
	logic [`MSG_ADDR_SIZE-1:0] rx_src;
	logic [`MSG_ADDR_SIZE-1:0] rx_dst;
	logic [`MSG_DATA_SIZE-1:0] rx_dat;
	logic                      err_src0;
	logic                      err_src1;
	logic                      row_end;
	logic                      exp_err0;
	logic                      exp_err1;
	int                        check_count;
	int                        mismatch_count;
	int                        other_count;
	int                        limit_cycles = 0;
	row_t                      rows[$];

	msg_test_top uut (
		.snk0_clk  (snk0_clk),
		.arst_n    (arst_n),
		.src_en    (src_en),
		.corrupt   (corrupt),
		.err_clear (err_clear),
		.rx_valid  (rx_valid),
		.rx_src    (rx_src),
		.rx_dst    (rx_dst),
		.rx_dat    (rx_dat),
		.err_src0  (err_src0),
		.err_src1  (err_src1)
	);

	msg_monitor u_monitor (
		.snk0_clk       (snk0_clk),
		.arst_n         (arst_n),
		.src_en         (src_en),
		.corrupt        (corrupt),
		.err_clear      (err_clear),
		.rx_valid       (rx_valid),
		.rx_src         (rx_src),
		.rx_dst         (rx_dst),
		.rx_dat         (rx_dat),
		.err_src0       (err_src0),
		.err_src1       (err_src1),
		.row_end        (row_end),
		.exp_err0       (exp_err0),
		.exp_err1       (exp_err1),
		.check_count    (check_count),
		.mismatch_count (mismatch_count),
		.other_count    (other_count)
	);

	initial begin
		snk0_clk = 1'b0;
		forever #(CLK_PERIOD / 2) snk0_clk = ~snk0_clk;
	end

	task automatic add_row(input logic [1:0] en, input logic [1:0] cor, input logic clr,
			input logic [15:0] cycles, input logic exp0, input logic exp1);
		row_t r;
		r.en      = en;
		r.corrupt = cor;
		r.clr     = clr;
		r.cycles  = cycles;
		r.exp0    = exp0;
		r.exp1    = exp1;
		rows.push_back(r);
	endtask

	task automatic build_table();
		//      en     corrupt clr   cycles   err0  err1
		add_row(2'b00, 2'b00, 1'b0, 16'd30,  1'b0, 1'b0);
		add_row(2'b01, 2'b00, 1'b0, 16'd260, 1'b0, 1'b0);
		add_row(2'b11, 2'b00, 1'b0, 16'd400, 1'b0, 1'b0);
		// Source 1 drains before its corrupt phase
		add_row(2'b01, 2'b00, 1'b0, 16'd60,  1'b0, 1'b0);
		add_row(2'b11, 2'b10, 1'b0, 16'd120, 1'b0, 1'b1);
		add_row(2'b11, 2'b00, 1'b0, 16'd80,  1'b0, 1'b1);
		add_row(2'b00, 2'b00, 1'b0, 16'd40,  1'b0, 1'b1);
		add_row(2'b00, 2'b00, 1'b1, 16'd2,   1'b0, 1'b0);
		add_row(2'b11, 2'b00, 1'b0, 16'd200, 1'b0, 1'b0);
		// Pause and resume source 1
		add_row(2'b01, 2'b00, 1'b0, 16'd100, 1'b0, 1'b0);
		add_row(2'b11, 2'b00, 1'b0, 16'd150, 1'b0, 1'b0);
	endtask

	function automatic int table_cycles();
		int sum;
		sum = 0;
		foreach (rows[i]) sum += int'(rows[i].cycles);
		return sum;
	endfunction

	// Row end pulse covers the last cycle of the row
	task automatic apply_row(input row_t r);
		src_en    = r.en;
		corrupt   = r.corrupt;
		err_clear = r.clr;
		exp_err0  = r.exp0;
		exp_err1  = r.exp1;
		repeat (int'(r.cycles) - 1) @(negedge snk0_clk);
		row_end = 1'b1;
		@(negedge snk0_clk);
		row_end = 1'b0;
	endtask

	initial begin
		arst_n    = 1'b0;
		src_en    = 2'b00;
		corrupt   = 2'b00;
		err_clear = 1'b0;
		row_end   = 1'b0;
		exp_err0  = 1'b0;
		exp_err1  = 1'b0;
		build_table();
		limit_cycles = RESET_CYCLES + table_cycles() + MARGIN_CYCLES;
		repeat (RESET_CYCLES) @(negedge snk0_clk);
		arst_n = 1'b1;
		foreach (rows[i]) apply_row(rows[i]);
		$display("Errors: %0d mismatches, %0d other failures, %0d messages checked",
			mismatch_count, other_count, check_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		wait (limit_cycles > 0);
		#(limit_cycles * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- src/calc_redun.sv
`include "msg_settings.svh"

module calc_redun (
	input  logic [`MSG_ADDR_SIZE-1:0]  src,
	input  logic [`MSG_ADDR_SIZE-1:0]  dst,
	input  logic [`MSG_DATA_SIZE-1:0]  dat,
	output logic [`MSG_REDUN_SIZE-1:0] redun
);

	localparam int WORD_W  = 2 * `MSG_ADDR_SIZE + `MSG_DATA_SIZE;
	localparam int NIBBLES = WORD_W / `MSG_REDUN_SIZE;

	logic [WORD_W-1:0] word;

	assign word = {src, dst, dat};

	// XOR of all nibbles
	always_comb begin
		redun = '0;
		for (int i = 0; i < NIBBLES; i++) begin
			redun = redun ^ word[i*`MSG_REDUN_SIZE +: `MSG_REDUN_SIZE];
		end
	end

endmodule

//--- src/msg_merge_2to1.sv
`include "msg_settings.svh"

module msg_merge_2to1
	import msg_pkg::*;
(
	input  logic                       snk0_clk,
	input  logic                       arst_n,
	input  logic                       in0_req,
	input  logic [`MSG_ADDR_SIZE-1:0]  in0_src,
	input  logic [`MSG_ADDR_SIZE-1:0]  in0_dst,
	input  logic [`MSG_DATA_SIZE-1:0]  in0_dat,
	input  logic [`MSG_REDUN_SIZE-1:0] in0_red,
	output logic                       in0_ack,
	input  logic                       in1_req,
	input  logic [`MSG_ADDR_SIZE-1:0]  in1_src,
	input  logic [`MSG_ADDR_SIZE-1:0]  in1_dst,
	input  logic [`MSG_DATA_SIZE-1:0]  in1_dat,
	input  logic [`MSG_REDUN_SIZE-1:0] in1_red,
	output logic                       in1_ack,
	output logic                       out_req,
	output logic [`MSG_ADDR_SIZE-1:0]  out_src,
	output logic [`MSG_ADDR_SIZE-1:0]  out_dst,
	output logic [`MSG_DATA_SIZE-1:0]  out_dat,
	output logic [`MSG_REDUN_SIZE-1:0] out_red,
	input  logic                       out_ack
);

	mrg_state_t state;
	// Last served input, also the one being forwarded
	logic       sel;
	logic       gnt;
	logic       grant_now;
	logic       sel_req;

	// Both requesting, favor the one not served last
	assign gnt       = (in0_req && in1_req) ? !sel : in1_req;
	assign grant_now = (state == MRG_IDLE) && (in0_req || in1_req);
	assign sel_req   = sel ? in1_req : in0_req;

	always_ff @(posedge snk0_clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= MRG_IDLE;
			sel     <= 1'b1;
			out_req <= 1'b0;
			in0_ack <= 1'b0;
			in1_ack <= 1'b0;
		end else begin
			case (state)
				MRG_IDLE: begin
					if (grant_now) begin
						sel     <= gnt;
						out_req <= 1'b1;
						state   <= MRG_SEND;
					end
				end
				MRG_SEND: begin
					if (out_ack) begin
						out_req <= 1'b0;
						in0_ack <= !sel;
						in1_ack <= sel;
						state   <= MRG_ACK_IN;
					end
				end
				MRG_ACK_IN: begin
					if (!sel_req) begin
						in0_ack <= 1'b0;
						in1_ack <= 1'b0;
						state   <= MRG_WAIT_LOW;
					end
				end
				MRG_WAIT_LOW: begin
					// Output channel must be idle before the next grant
					if (!out_ack) begin
						state <= MRG_IDLE;
					end
				end
				default: state <= MRG_IDLE;
			endcase
		end
	end

	// Holding register
	always_ff @(posedge snk0_clk) begin
		if (grant_now) begin
			out_src <= gnt ? in1_src : in0_src;
			out_dst <= gnt ? in1_dst : in0_dst;
			out_dat <= gnt ? in1_dat : in0_dat;
			out_red <= gnt ? in1_red : in0_red;
		end
	end

	// Granted input holds its fields while the copy is forwarded
	a_fwd_match: assert property (@(posedge snk0_clk) disable iff (!arst_n)
		out_req |-> {out_src, out_dst, out_dat, out_red} == (sel
			? {in1_src, in1_dst, in1_dat, in1_red}
			: {in0_src, in0_dst, in0_dat, in0_red}));

endmodule

//--- src/msg_pkg.sv
package msg_pkg;

	// Source message build sequence
	typedef enum logic [7:0] {
		SRC_DST,
		SRC_DAT,
		SRC_RED,
		SRC_REQ,
		SRC_DROP
	} src_state_t;

	// Merge forward sequence
	typedef enum logic [7:0] {
		MRG_IDLE,
		MRG_SEND,
		MRG_ACK_IN,
		MRG_WAIT_LOW
	} mrg_state_t;

	// Sink receive and check sequence
	typedef enum logic [7:0] {
		SNK_IDLE,
		SNK_REDUN,
		SNK_CHECK,
		SNK_ACK
	} snk_state_t;

endpackage

//--- src/msg_settings.svh
`ifndef MSG_SETTINGS_SVH
`define MSG_SETTINGS_SVH

// Message field widths
`define MSG_ADDR_SIZE 4
`define MSG_DATA_SIZE 8
`define MSG_REDUN_SIZE 4

// Destination addresses cycle through this range
`define MSG_MIN_ADDR 1
`define MSG_MAX_ADDR 3

// Source addresses
`define MSG_SRC0_ADDR 0
`define MSG_SRC1_ADDR 1

`endif

//--- src/msg_sink_check.sv
`include "msg_settings.svh"

module msg_sink_check
	import msg_pkg::*;
(
	input  logic                       snk0_clk,
	input  logic                       arst_n,
	input  logic                       err_clear,
	input  logic                       i0_req,
	input  logic [`MSG_ADDR_SIZE-1:0]  i0_src,
	input  logic [`MSG_ADDR_SIZE-1:0]  i0_dst,
	input  logic [`MSG_DATA_SIZE-1:0]  i0_dat,
	input  logic [`MSG_REDUN_SIZE-1:0] i0_red,
	output logic                       i0_ack,
	output logic                       rx_valid,
	output logic [`MSG_ADDR_SIZE-1:0]  rx_src,
	output logic [`MSG_ADDR_SIZE-1:0]  rx_dst,
	output logic [`MSG_DATA_SIZE-1:0]  rx_dat,
	output logic                       err_src0,
	output logic                       err_src1
);

	localparam logic [`MSG_ADDR_SIZE-1:0] SRC0_A = `MSG_ADDR_SIZE'(`MSG_SRC0_ADDR);
	localparam logic [`MSG_ADDR_SIZE-1:0] SRC1_A = `MSG_ADDR_SIZE'(`MSG_SRC1_ADDR);
	localparam logic [`MSG_DATA_SIZE-1:0] LAST_INIT = `MSG_DATA_SIZE'(15);
	localparam logic [`MSG_DATA_SIZE-1:0] LAST_SEQ = `MSG_DATA_SIZE'(14);

	snk_state_t                 state;
	logic [`MSG_REDUN_SIZE-1:0] rx_red;
	logic [`MSG_REDUN_SIZE-1:0] calc;
	logic [`MSG_REDUN_SIZE-1:0] calc_q;
	logic [`MSG_DATA_SIZE-1:0]  last0;
	logic [`MSG_DATA_SIZE-1:0]  last1;
	logic                       do_check;
	logic                       red_bad;

	assign do_check = (state == SNK_CHECK);
	assign red_bad  = (rx_red != calc_q);

	calc_redun u_calc_redun (
		.src   (rx_src),
		.dst   (rx_dst),
		.dat   (rx_dat),
		.redun (calc)
	);

	always_ff @(posedge snk0_clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= SNK_IDLE;
			i0_ack   <= 1'b0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				SNK_IDLE:  if (i0_req) state <= SNK_REDUN;
				SNK_REDUN: state <= SNK_CHECK;
				SNK_CHECK: state <= SNK_ACK;
				SNK_ACK: begin
					if (!i0_ack) begin
						i0_ack   <= 1'b1;
						rx_valid <= 1'b1;
					end else if (!i0_req) begin
						i0_ack <= 1'b0;
						state  <= SNK_IDLE;
					end
				end
				default: state <= SNK_IDLE;
			endcase
		end
	end

	// Captured message and recomputed code
	always_ff @(posedge snk0_clk) begin
		if (state == SNK_IDLE && i0_req) begin
			rx_src <= i0_src;
			rx_dst <= i0_dst;
			rx_dat <= i0_dat;
			rx_red <= i0_red;
		end
		if (state == SNK_REDUN) begin
			calc_q <= calc;
		end
	end

	// Sticky errors and per-source sequence
	always_ff @(posedge snk0_clk or negedge arst_n) begin
		if (!arst_n) begin
			err_src0 <= 1'b0;
			err_src1 <= 1'b0;
			last0    <= LAST_INIT;
			last1    <= LAST_INIT;
		end else if (err_clear) begin
			err_src0 <= 1'b0;
			err_src1 <= 1'b0;
			last0    <= LAST_INIT;
			last1    <= LAST_INIT;
		end else if (do_check) begin
			if (rx_src == SRC0_A && !err_src0) begin
				if (red_bad) begin
					err_src0 <= 1'b1;
				end else if (last0 <= LAST_SEQ && last0 + 1'b1 != rx_dat) begin
					err_src0 <= 1'b1;
				end else begin
					last0 <= rx_dat;
				end
			end
			if (rx_src == SRC1_A && !err_src1) begin
				if (red_bad) begin
					err_src1 <= 1'b1;
				end else if (last1 <= LAST_SEQ && last1 + 1'b1 != rx_dat) begin
					err_src1 <= 1'b1;
				end else begin
					last1 <= rx_dat;
				end
			end
		end
	end

	// Sender still presents the captured message when ack rises
	a_msg_held: assert property (@(posedge snk0_clk) disable iff (!arst_n)
		rx_valid |-> i0_req &&
			{i0_src, i0_dst, i0_dat, i0_red} == {rx_src, rx_dst, rx_dat, rx_red});

endmodule

//--- src/msg_source.sv
`include "msg_settings.svh"

module msg_source
	import msg_pkg::*;
#(
	parameter logic [`MSG_ADDR_SIZE-1:0] SRC_ADDR = `MSG_ADDR_SIZE'(`MSG_SRC0_ADDR)
)(
	input  logic                       snk0_clk,
	input  logic                       arst_n,
	input  logic                       en,
	input  logic                       corrupt,
	output logic                       req,
	output logic [`MSG_ADDR_SIZE-1:0]  src,
	output logic [`MSG_ADDR_SIZE-1:0]  dst,
	output logic [`MSG_DATA_SIZE-1:0]  dat,
	output logic [`MSG_REDUN_SIZE-1:0] red,
	input  logic                       ack
);

	localparam logic [`MSG_ADDR_SIZE-1:0] MIN_A = `MSG_ADDR_SIZE'(`MSG_MIN_ADDR);
	localparam logic [`MSG_ADDR_SIZE-1:0] MAX_A = `MSG_ADDR_SIZE'(`MSG_MAX_ADDR);

	src_state_t                 state;
	logic [3:0]                 cnt;
	logic [`MSG_ADDR_SIZE-1:0]  dst_next;
	logic [`MSG_REDUN_SIZE-1:0] redun;

	assign src      = SRC_ADDR;
	assign dst_next = (dst == MAX_A) ? MIN_A : dst + 1'b1;

	calc_redun u_calc_redun (
		.src   (src),
		.dst   (dst),
		.dat   (dat),
		.redun (redun)
	);

	always_ff @(posedge snk0_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= SRC_DST;
			req   <= 1'b0;
			dst   <= MAX_A;
			cnt   <= '0;
		end else begin
			case (state)
				SRC_DST: begin
					// Start only on an idle channel
					if (en && !req && !ack) begin
						dst   <= dst_next;
						state <= SRC_DAT;
					end
				end
				SRC_DAT: begin
					cnt   <= cnt + 1'b1;
					state <= SRC_RED;
				end
				SRC_RED: begin
					state <= SRC_REQ;
				end
				SRC_REQ: begin
					req   <= 1'b1;
					state <= SRC_DROP;
				end
				SRC_DROP: begin
					if (ack) begin
						req   <= 1'b0;
						state <= SRC_DST;
					end
				end
				default: state <= SRC_DST;
			endcase
		end
	end

	// Payload fields
	always_ff @(posedge snk0_clk) begin
		if (state == SRC_DAT) begin
			dat <= {{(`MSG_DATA_SIZE-4){1'b0}}, cnt};
		end
		if (state == SRC_RED) begin
			// Corrupt flips bit 0 of the code
			red <= redun ^ {{(`MSG_REDUN_SIZE-1){1'b0}}, corrupt};
		end
	end

	a_fields_stable: assert property (@(posedge snk0_clk) disable iff (!arst_n)
		req && $past(req) |-> $stable({dst, dat, red}));

	a_no_req_on_ack: assert property (@(posedge snk0_clk) disable iff (!arst_n)
		!req && ack |=> !req);

endmodule

//--- src/msg_test_top.sv
`include "msg_settings.svh"

module msg_test_top (
	input  logic                      snk0_clk,
	input  logic                      arst_n,
	input  logic [1:0]                src_en,
	input  logic [1:0]                corrupt,
	input  logic                      err_clear,
	output logic                      rx_valid,
	output logic [`MSG_ADDR_SIZE-1:0] rx_src,
	output logic [`MSG_ADDR_SIZE-1:0] rx_dst,
	output logic [`MSG_DATA_SIZE-1:0] rx_dat,
	output logic                      err_src0,
	output logic                      err_src1
);

	logic                       s0_req;
	logic [`MSG_ADDR_SIZE-1:0]  s0_src;
	logic [`MSG_ADDR_SIZE-1:0]  s0_dst;
	logic [`MSG_DATA_SIZE-1:0]  s0_dat;
	logic [`MSG_REDUN_SIZE-1:0] s0_red;
	logic                       s0_ack;
	logic                       s1_req;
	logic [`MSG_ADDR_SIZE-1:0]  s1_src;
	logic [`MSG_ADDR_SIZE-1:0]  s1_dst;
	logic [`MSG_DATA_SIZE-1:0]  s1_dat;
	logic [`MSG_REDUN_SIZE-1:0] s1_red;
	logic                       s1_ack;
	logic                       m_req;
	logic [`MSG_ADDR_SIZE-1:0]  m_src;
	logic [`MSG_ADDR_SIZE-1:0]  m_dst;
	logic [`MSG_DATA_SIZE-1:0]  m_dat;
	logic [`MSG_REDUN_SIZE-1:0] m_red;
	logic                       m_ack;

	msg_source #(.SRC_ADDR(`MSG_ADDR_SIZE'(`MSG_SRC0_ADDR))) u_src0 (
		.snk0_clk (snk0_clk), .arst_n (arst_n), .en (src_en[0]), .corrupt (corrupt[0]),
		.req (s0_req), .src (s0_src), .dst (s0_dst), .dat (s0_dat), .red (s0_red),
		.ack (s0_ack)
	);

	msg_source #(.SRC_ADDR(`MSG_ADDR_SIZE'(`MSG_SRC1_ADDR))) u_src1 (
		.snk0_clk (snk0_clk), .arst_n (arst_n), .en (src_en[1]), .corrupt (corrupt[1]),
		.req (s1_req), .src (s1_src), .dst (s1_dst), .dat (s1_dat), .red (s1_red),
		.ack (s1_ack)
	);

	msg_merge_2to1 u_merge (
		.snk0_clk (snk0_clk), .arst_n (arst_n),
		.in0_req (s0_req), .in0_src (s0_src), .in0_dst (s0_dst), .in0_dat (s0_dat),
		.in0_red (s0_red), .in0_ack (s0_ack),
		.in1_req (s1_req), .in1_src (s1_src), .in1_dst (s1_dst), .in1_dat (s1_dat),
		.in1_red (s1_red), .in1_ack (s1_ack),
		.out_req (m_req), .out_src (m_src), .out_dst (m_dst), .out_dat (m_dat),
		.out_red (m_red), .out_ack (m_ack)
	);

	msg_sink_check u_sink (
		.snk0_clk (snk0_clk), .arst_n (arst_n), .err_clear (err_clear),
		.i0_req (m_req), .i0_src (m_src), .i0_dst (m_dst), .i0_dat (m_dat),
		.i0_red (m_red), .i0_ack (m_ack),
		.rx_valid (rx_valid), .rx_src (rx_src), .rx_dst (rx_dst), .rx_dat (rx_dat),
		.err_src0 (err_src0), .err_src1 (err_src1)
	);

endmodule

//--- tb.f
+incdir+src
src/msg_pkg.sv
src/calc_redun.sv
src/msg_source.sv
src/msg_merge_2to1.sv
src/msg_sink_check.sv
src/msg_test_top.sv
sim/msg_monitor.sv
sim/tb_msg_test.sv
